// File: sss_pkg.sv
package sss_pkg;

    // SSS sequence geometry
    localparam int SSS_LEN   = 127;
    localparam int SEQ_IDX_W = 7;

    // cell identity limits
    localparam int N_ID_1_MAX = 335;
    localparam int N_ID_1_W   = 9;
    localparam int N_ID_2_W   = 2;

    // m_1 runs 0..111 inside one m_0 group
    localparam int SHIFT_MAX = 112;
    localparam int GROUP_W   = 2;

    // m_0 = 15 * (N_id_1 / 112) + 5 * N_id_2
    localparam int M0_STEP = 15;

    // a match count spans 0..127
    localparam int SCORE_W = 7;

    // m-sequence generators
    localparam int LFSR_W = 7;
    // x(i+7) = x(i+4) + x(i)
    localparam logic [LFSR_W-1:0] MSEQ0_TAPS = 7'h11;
    // x(i+7) = x(i+1) + x(i)
    localparam logic [LFSR_W-1:0] MSEQ1_TAPS = 7'h03;
    localparam logic [LFSR_W-1:0] LFSR_SEED  = 7'd1;

endpackage

// File: sss_if.sv
`timescale 1ns/10ps

// one SSS candidate, generator to correlator
interface sss_cand_if;
    logic                          valid;
    logic                          ready;
    logic [sss_pkg::SEQ_IDX_W-1:0] m_0;
    logic [sss_pkg::SEQ_IDX_W-1:0] m_1;
    logic [sss_pkg::N_ID_1_W-1:0]  n_id_1;
    logic                          last;

    modport source (output valid, m_0, m_1, n_id_1, last, input ready);
    modport sink (input valid, m_0, m_1, n_id_1, last, output ready);
endinterface

// match count of one candidate, no back-pressure
interface sss_score_if;
    logic                         valid;
    logic [sss_pkg::SCORE_W-1:0]  score;
    logic [sss_pkg::N_ID_1_W-1:0] n_id_1;
    logic                         last;

    modport source (output valid, score, n_id_1, last);
    modport sink (input valid, score, n_id_1, last);
endinterface

// File: mseq_lfsr.sv
`timescale 1ns/10ps

module mseq_lfsr #(
    parameter logic [sss_pkg::LFSR_W-1:0] TAPS = sss_pkg::MSEQ0_TAPS,
    parameter logic [sss_pkg::LFSR_W-1:0] SEED = sss_pkg::LFSR_SEED
) (
    input  logic clk_i,
    input  logic reset_ni,
    output logic chip_o,
    output logic chip_valid_o
);

    logic [sss_pkg::LFSR_W-1:0]    state_q;
    logic [sss_pkg::SEQ_IDX_W-1:0] chip_cnt_q;
    logic                          feedback;

    // state_q[0] is the oldest chip x(i), feedback becomes x(i+7)
    assign feedback     = ^(state_q & TAPS);
    assign chip_o       = state_q[0];
    assign chip_valid_o = (chip_cnt_q < sss_pkg::SSS_LEN);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q    <= SEED;
            chip_cnt_q <= '0;
        end else begin
            state_q <= {feedback, state_q[sss_pkg::LFSR_W-1:1]};
            // one period only, counter parks at SSS_LEN
            if (chip_valid_o) begin
                chip_cnt_q <= chip_cnt_q + 1'b1;
            end
        end
    end

    // an all-zero state would lock the generator
    a_state_nonzero: assert property (@(posedge clk_i) disable iff (!reset_ni)
        state_q != '0);

endmodule

// File: sss_capture.sv
`timescale 1ns/10ps

module sss_capture (
    input  logic                         clk_i,
    input  logic                         reset_ni,
    input  logic                         bit_i,
    input  logic                         bit_valid_i,
    input  logic [sss_pkg::N_ID_2_W-1:0] n_id_2_i,
    input  logic                         n_id_2_valid_i,
    input  logic                         done_i,
    output logic [sss_pkg::SSS_LEN-1:0]  buf_bits_o,
    output logic [sss_pkg::N_ID_2_W-1:0] n_id_2_o,
    output logic                         start_o
);

    logic [sss_pkg::SEQ_IDX_W-1:0] wr_idx_q;
    logic                          busy_q;
    logic                          start_q;
    logic [sss_pkg::SSS_LEN-1:0]   buf_q;
    logic [sss_pkg::N_ID_2_W-1:0]  n_id_2_q;
    logic                          take_bit;

    // bits arriving during a search are dropped
    assign take_bit = bit_valid_i && !busy_q;

    always_ff @(posedge clk_i) begin
        if (take_bit) begin
            buf_q[wr_idx_q] <= bit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_idx_q <= '0;
            busy_q   <= 1'b0;
            start_q  <= 1'b0;
            n_id_2_q <= '0;
        end else begin
            start_q <= 1'b0;
            if (n_id_2_valid_i && !busy_q) begin
                n_id_2_q <= n_id_2_i;
            end
            if (take_bit) begin
                if (wr_idx_q == sss_pkg::SSS_LEN - 1) begin
                    wr_idx_q <= '0;
                    busy_q   <= 1'b1;
                    start_q  <= 1'b1;
                end else begin
                    wr_idx_q <= wr_idx_q + 1'b1;
                end
            end else if (busy_q && done_i) begin
                // peak picker finished, re-arm
                busy_q <= 1'b0;
            end
        end
    end

    assign buf_bits_o = buf_q;
    assign n_id_2_o   = n_id_2_q;
    assign start_o    = start_q;

    // a result only comes back for a search this stage started
    a_done_while_busy: assert property (@(posedge clk_i) disable iff (!reset_ni)
        done_i |-> busy_q);

endmodule

// File: sss_candidate_gen.sv
`timescale 1ns/10ps

module sss_candidate_gen (
    input  logic                         clk_i,
    input  logic                         reset_ni,
    input  logic                         start_i,
    input  logic [sss_pkg::N_ID_2_W-1:0] n_id_2_i,
    sss_cand_if.source                   cand
);

    logic                          valid_q;
    logic [sss_pkg::SEQ_IDX_W-1:0] shift_q;
    logic [sss_pkg::GROUP_W-1:0]   group_q;
    logic [sss_pkg::SEQ_IDX_W-1:0] m_0_q;
    logic [sss_pkg::N_ID_1_W-1:0]  n_id_1_q;
    logic [sss_pkg::SEQ_IDX_W-1:0] m_0_base;
    logic                          shift_wrap;
    logic                          last;
    logic                          xfer;

    // 5 * N_id_2 as 4n + n
    assign m_0_base   = {n_id_2_i, 2'b00} + n_id_2_i;
    assign shift_wrap = (shift_q == sss_pkg::SHIFT_MAX - 1);
    // N_id_1 335 is shift 111 of group 2
    assign last = shift_wrap && (group_q == sss_pkg::N_ID_1_MAX / sss_pkg::SHIFT_MAX);
    assign xfer = valid_q && cand.ready;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_q  <= 1'b0;
            shift_q  <= '0;
            group_q  <= '0;
            m_0_q    <= '0;
            n_id_1_q <= '0;
        end else if (start_i) begin
            valid_q  <= 1'b1;
            shift_q  <= '0;
            group_q  <= '0;
            m_0_q    <= m_0_base;
            n_id_1_q <= '0;
        end else if (xfer) begin
            if (last) begin
                valid_q <= 1'b0;
            end else if (shift_wrap) begin
                // next m_0 group
                shift_q <= '0;
                group_q <= group_q + 1'b1;
                m_0_q   <= m_0_q + sss_pkg::SEQ_IDX_W'(sss_pkg::M0_STEP);
            end else begin
                shift_q <= shift_q + 1'b1;
            end
            n_id_1_q <= n_id_1_q + 1'b1;
        end
    end

    assign cand.valid  = valid_q;
    assign cand.m_0    = m_0_q;
    assign cand.m_1    = shift_q;
    assign cand.n_id_1 = n_id_1_q;
    assign cand.last   = last;

endmodule

// File: sss_correlator.sv
`timescale 1ns/10ps

module sss_correlator (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  logic [sss_pkg::SSS_LEN-1:0] buf_bits_i,
    sss_cand_if.sink                    cand,
    sss_score_if.source                 score
);

    logic [sss_pkg::SSS_LEN-1:0]   m_seq_0_q;
    logic [sss_pkg::SSS_LEN-1:0]   m_seq_1_q;
    logic [sss_pkg::SEQ_IDX_W-1:0] fill_idx_q;
    logic                          table_ready_q;
    logic                          chip_0;
    logic                          chip_1;
    logic                          chip_0_valid;
    logic                          chip_1_valid;
    logic                          wr_en;

    logic                          busy_q;
    logic [sss_pkg::SEQ_IDX_W-1:0] cmp_idx_q;
    logic [sss_pkg::SEQ_IDX_W-1:0] pos_0_q;
    logic [sss_pkg::SEQ_IDX_W-1:0] pos_1_q;
    logic [sss_pkg::SCORE_W-1:0]   acc_q;
    logic [sss_pkg::N_ID_1_W-1:0]  n_id_1_q;
    logic                          last_q;
    logic                          score_valid_q;
    logic                          xfer;
    logic                          match;

    mseq_lfsr #(
        .TAPS (sss_pkg::MSEQ0_TAPS),
        .SEED (sss_pkg::LFSR_SEED)
    ) mseq_0_inst (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .chip_o       (chip_0),
        .chip_valid_o (chip_0_valid)
    );

    mseq_lfsr #(
        .TAPS (sss_pkg::MSEQ1_TAPS),
        .SEED (sss_pkg::LFSR_SEED)
    ) mseq_1_inst (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .chip_o       (chip_1),
        .chip_valid_o (chip_1_valid)
    );

    assign wr_en = chip_0_valid && chip_1_valid;

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            m_seq_0_q[fill_idx_q] <= chip_0;
            m_seq_1_q[fill_idx_q] <= chip_1;
        end
    end

    assign cand.ready = table_ready_q && !busy_q;
    assign xfer       = cand.valid && cand.ready;

    // hard bit of d_SSS is the XOR of both shifted chips
    assign match = (buf_bits_i[cmp_idx_q] == (m_seq_0_q[pos_0_q] ^ m_seq_1_q[pos_1_q]));

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            fill_idx_q    <= '0;
            table_ready_q <= 1'b0;
            busy_q        <= 1'b0;
            score_valid_q <= 1'b0;
            cmp_idx_q     <= '0;
        end else begin
            score_valid_q <= 1'b0;
            if (wr_en) begin
                fill_idx_q <= fill_idx_q + 1'b1;
                if (fill_idx_q == sss_pkg::SSS_LEN - 1) begin
                    table_ready_q <= 1'b1;
                end
            end
            if (xfer) begin
                busy_q    <= 1'b1;
                cmp_idx_q <= '0;
            end else if (busy_q) begin
                cmp_idx_q <= cmp_idx_q + 1'b1;
                if (cmp_idx_q == sss_pkg::SSS_LEN - 1) begin
                    busy_q        <= 1'b0;
                    score_valid_q <= 1'b1;
                end
            end
        end
    end

    // positions wrap at 127, so no overflow trick is possible
    always_ff @(posedge clk_i) begin
        if (xfer) begin
            pos_0_q  <= cand.m_0;
            pos_1_q  <= cand.m_1;
            acc_q    <= '0;
            n_id_1_q <= cand.n_id_1;
            last_q   <= cand.last;
        end else if (busy_q) begin
            acc_q   <= acc_q + match;
            pos_0_q <= (pos_0_q == sss_pkg::SSS_LEN - 1) ? '0 : pos_0_q + 1'b1;
            pos_1_q <= (pos_1_q == sss_pkg::SSS_LEN - 1) ? '0 : pos_1_q + 1'b1;
        end
    end

    assign score.valid  = score_valid_q;
    assign score.score  = acc_q;
    assign score.n_id_1 = n_id_1_q;
    assign score.last   = last_q;

    // a candidate occupies the counter for 127 cycles, then its score appears
    a_count_window: assert property (@(posedge clk_i) disable iff (!reset_ni)
        xfer |=> !xfer [*sss_pkg::SSS_LEN] ##1 score.valid);

endmodule

// File: sss_peak_pick.sv
`timescale 1ns/10ps

module sss_peak_pick (
    input  logic                         clk_i,
    input  logic                         reset_ni,
    sss_score_if.sink                    score,
    output logic [sss_pkg::N_ID_1_W-1:0] n_id_1_o,
    output logic                         n_id_1_valid_o,
    output logic                         done_o
);

    logic [sss_pkg::SCORE_W-1:0]  best_score_q;
    logic [sss_pkg::N_ID_1_W-1:0] best_id_q;
    logic [sss_pkg::N_ID_1_W-1:0] n_id_1_q;
    logic                         valid_q;
    logic                         done_q;
    logic                         better;
    logic [sss_pkg::N_ID_1_W-1:0] winner;

    // strict compare keeps the lowest N_id_1 on a tie
    assign better = (score.score > best_score_q);
    assign winner = better ? score.n_id_1 : best_id_q;

    always_ff @(posedge clk_i) begin
        if (score.valid && score.last) begin
            n_id_1_q <= winner;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            best_score_q <= '0;
            best_id_q    <= '0;
            valid_q      <= 1'b0;
            done_q       <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            done_q  <= 1'b0;
            if (score.valid && score.last) begin
                valid_q      <= 1'b1;
                done_q       <= 1'b1;
                best_score_q <= '0;
                best_id_q    <= '0;
            end else if (score.valid && better) begin
                best_score_q <= score.score;
                best_id_q    <= score.n_id_1;
            end
        end
    end

    assign n_id_1_o       = n_id_1_q;
    assign n_id_1_valid_o = valid_q;
    assign done_o         = done_q;

endmodule

// File: sss_detector.sv
`timescale 1ns/10ps

module sss_detector (
    input  logic                         clk_i,
    input  logic                         reset_ni,
    input  logic                         s_axis_in_tdata,
    input  logic                         s_axis_in_tvalid,
    input  logic [sss_pkg::N_ID_2_W-1:0] n_id_2_i,
    input  logic                         n_id_2_valid_i,
    output logic [sss_pkg::N_ID_1_W-1:0] m_axis_out_tdata,
    output logic                         m_axis_out_tvalid
);

    logic [sss_pkg::SSS_LEN-1:0]  buf_bits;
    logic [sss_pkg::N_ID_2_W-1:0] n_id_2;
    logic                         start;
    logic                         done;

    sss_cand_if  cand_if ();
    sss_score_if score_if ();

    // decode
    sss_capture sss_capture_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .bit_i          (s_axis_in_tdata),
        .bit_valid_i    (s_axis_in_tvalid),
        .n_id_2_i       (n_id_2_i),
        .n_id_2_valid_i (n_id_2_valid_i),
        .done_i         (done),
        .buf_bits_o     (buf_bits),
        .n_id_2_o       (n_id_2),
        .start_o        (start)
    );

    sss_candidate_gen sss_candidate_gen_inst (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .start_i  (start),
        .n_id_2_i (n_id_2),
        .cand     (cand_if.source)
    );

    // execute
    sss_correlator sss_correlator_inst (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .buf_bits_i (buf_bits),
        .cand       (cand_if.sink),
        .score      (score_if.source)
    );

    // result
    sss_peak_pick sss_peak_pick_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .score          (score_if.sink),
        .n_id_1_o       (m_axis_out_tdata),
        .n_id_1_valid_o (m_axis_out_tvalid),
        .done_o         (done)
    );

endmodule

// File: sss_checker.sv
`timescale 1ns/10ps

module sss_checker (
    input  logic                         clk_i,
    input  logic                         reset_ni,
    input  logic                         tvalid_i,
    input  logic [sss_pkg::N_ID_1_W-1:0] tdata_i,
    input  logic                         exp_push_i,
    input  logic [sss_pkg::N_ID_1_W-1:0] exp_data_i,
    output int                           pass_count_o,
    output int                           fail_count_o,
    output int                           result_count_o
);

    logic [sss_pkg::N_ID_1_W-1:0] expected_q[$];
    logic [sss_pkg::N_ID_1_W-1:0] want;
    int                           pass_count = 0;
    int                           fail_count = 0;
    int                           result_count = 0;

    // outputs change on the rising edge, so look at them half a period later
    always @(negedge clk_i) begin
        if (reset_ni) begin
            if (exp_push_i) begin
                expected_q.push_back(exp_data_i);
            end
            if ($isunknown(tvalid_i)) begin
                $display("m_axis_out_tvalid is unknown at %0t", $time);
                fail_count++;
            end else if (tvalid_i) begin
                if (expected_q.size() == 0) begin
                    // a second pulse or a pulse before any search
                    $display("result pulse with no search pending, after test %0d at %0t",
                             result_count, $time);
                    fail_count++;
                end else begin
                    want = expected_q.pop_front();
                    result_count++;
                    if (tdata_i !== want) begin
                        $display("mismatch m_axis_out_tdata in test %0d: expected 0x%h, got 0x%h",
                                 result_count, want, tdata_i);
                        fail_count++;
                    end else begin
                        $display("test %0d finished: m_axis_out_tdata 0x%h as expected",
                                 result_count, tdata_i);
                        pass_count++;
                    end
                end
            end
        end
    end

    assign pass_count_o   = pass_count;
    assign fail_count_o   = fail_count;
    assign result_count_o = result_count;

endmodule

// File: sss_detector_tb.sv
`timescale 1ns/10ps

module sss_detector_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int LEN          = sss_pkg::SSS_LEN;
    // a full sweep of 336 candidates plus margin for capture and table fill
    localparam longint TEST_CYCLES = 336 * 130 + 400;

    logic                         clk_i = 1'b0;
    logic                         reset_ni;
    logic                         s_axis_in_tdata;
    logic                         s_axis_in_tvalid;
    logic [sss_pkg::N_ID_2_W-1:0] n_id_2_i;
    logic                         n_id_2_valid_i;
    logic [sss_pkg::N_ID_1_W-1:0] m_axis_out_tdata;
    logic                         m_axis_out_tvalid;
    logic                         exp_push;
    logic [sss_pkg::N_ID_1_W-1:0] exp_data;
    int                           pass_count;
    int                           fail_count;
    int                           result_count;

    logic x0 [LEN];
    logic x1 [LEN];
    int   test_n_id_2[$];
    int   test_n_id_1[$];
    int   test_flips[$];
    int   test_extra[$];
    int   test_expect[$];
    int   load_errors = 0;
    bit   tests_loaded = 1'b0;

    sss_detector sss_detector_inst (
        .clk_i             (clk_i),
        .reset_ni          (reset_ni),
        .s_axis_in_tdata   (s_axis_in_tdata),
        .s_axis_in_tvalid  (s_axis_in_tvalid),
        .n_id_2_i          (n_id_2_i),
        .n_id_2_valid_i    (n_id_2_valid_i),
        .m_axis_out_tdata  (m_axis_out_tdata),
        .m_axis_out_tvalid (m_axis_out_tvalid)
    );

    sss_checker sss_checker_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .tvalid_i       (m_axis_out_tvalid),
        .tdata_i        (m_axis_out_tdata),
        .exp_push_i     (exp_push),
        .exp_data_i     (exp_data),
        .pass_count_o   (pass_count),
        .fail_count_o   (fail_count),
        .result_count_o (result_count)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // x(i+7) = x(i+4) + x(i) and x(i+7) = x(i+1) + x(i), both start at x(0) = 1
    function automatic void build_msequences();
        for (int i = 0; i < LEN; i++) begin
            if (i < 7) begin
                x0[i] = (i == 0);
                x1[i] = (i == 0);
            end else begin
                x0[i] = x0[i-3] ^ x0[i-7];
                x1[i] = x1[i-6] ^ x1[i-7];
            end
        end
    endfunction

    // product of the two +-1 chips becomes the XOR of the hard bits
    function automatic logic sss_chip(int n_id_1, int n_id_2, int n);
        int m0;
        int m1;
        m0 = 15 * (n_id_1 / 112) + 5 * n_id_2;
        m1 = n_id_1 % 112;
        return x0[(n + m0) % LEN] ^ x1[(n + m1) % LEN];
    endfunction

    task automatic load_tests();
        int                fd;
        int                fields;
        int                a;
        int                b;
        int                c;
        int                d;
        int                e;
        logic [8*96-1:0]   line_buf;
        fd = $fopen("sss_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open sss_stimulus.txt");
            load_errors++;
        end else begin
            while (!$feof(fd)) begin
                line_buf = '0;
                if ($fgets(line_buf, fd) != 0) begin
                    // comment and blank lines scan no number
                    fields = $sscanf(line_buf, "%d %d %d %d %d", a, b, c, d, e);
                    if (fields == 5) begin
                        test_n_id_2.push_back(a);
                        test_n_id_1.push_back(b);
                        test_flips.push_back(c);
                        test_extra.push_back(d);
                        test_expect.push_back(e);
                    end else if (fields > 0) begin
                        $display("malformed line in sss_stimulus.txt");
                        load_errors++;
                    end
                end
            end
            $fclose(fd);
        end
        if (test_expect.size() == 0) begin
            $display("no tests found in sss_stimulus.txt");
            load_errors++;
        end
    endtask

    task automatic run_search(int idx);
        logic [LEN-1:0] seq;
        bit             flipped [LEN];
        int             pos;
        for (int n = 0; n < LEN; n++) begin
            seq[n]     = sss_chip(test_n_id_1[idx], test_n_id_2[idx], n);
            flipped[n] = 1'b0;
        end
        // noise at distinct positions
        for (int k = 0; k < test_flips[idx]; k++) begin
            pos = $urandom % LEN;
            while (flipped[pos]) begin
                pos = (pos + 1) % LEN;
            end
            flipped[pos] = 1'b1;
            seq[pos]     = ~seq[pos];
        end
        @(posedge clk_i);
        exp_push       <= 1'b1;
        exp_data       <= test_expect[idx][sss_pkg::N_ID_1_W-1:0];
        n_id_2_i       <= test_n_id_2[idx][sss_pkg::N_ID_2_W-1:0];
        n_id_2_valid_i <= 1'b1;
        @(posedge clk_i);
        exp_push         <= 1'b0;
        n_id_2_valid_i   <= 1'b0;
        s_axis_in_tvalid <= 1'b1;
        s_axis_in_tdata  <= seq[0];
        for (int n = 1; n < LEN; n++) begin
            @(posedge clk_i);
            s_axis_in_tdata <= seq[n];
        end
        // these land while the search runs
        for (int x = 0; x < test_extra[idx]; x++) begin
            @(posedge clk_i);
            s_axis_in_tdata <= 1'($urandom);
        end
        @(posedge clk_i);
        s_axis_in_tvalid <= 1'b0;
        while (result_count <= idx) begin
            @(negedge clk_i);
        end
        // capture re-arms on the done pulse
        repeat (2) @(posedge clk_i);
    endtask

    initial begin
        reset_ni         = 1'b0;
        s_axis_in_tdata  = 1'b0;
        s_axis_in_tvalid = 1'b0;
        n_id_2_i         = '0;
        n_id_2_valid_i   = 1'b0;
        exp_push         = 1'b0;
        exp_data         = '0;
        void'($urandom(32'hd2b69fca));
        build_msequences();
        load_tests();
        tests_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_ni <= 1'b1;
        for (int t = 0; t < test_expect.size(); t++) begin
            run_search(t);
        end
        // leave room for a stray result pulse
        repeat (400) @(posedge clk_i);
        $display("tests %0d, passed %0d, failed %0d",
                 test_expect.size(), pass_count, fail_count + load_errors);
        if (load_errors == 0 && fail_count == 0 && pass_count == test_expect.size()) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        longint limit_cycles;
        wait (tests_loaded);
        limit_cycles = (test_expect.size() + 1) * TEST_CYCLES + RESET_CYCLES;
        #(limit_cycles * CLK_PERIOD);
        $display("timeout: searches did not finish within %0d cycles", limit_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: sss_stimulus.txt
# n_id_2  n_id_1  flipped_bits  extra_bits  expected_n_id_1   (decimal)
# the extra bits arrive while the search runs and must be ignored
0   0    0   0    0
1   111  0   0    111
2   112  0   0    112
0   335  0   0    335
1   200  6   0    200
2   57   12  40   57
0   250  12  0    250
2   335  3   127  335
1   0    12  16   0
0   168  0   5    168

// File: flist.f
sss_pkg.sv
sss_if.sv
mseq_lfsr.sv
sss_capture.sv
sss_candidate_gen.sv
sss_correlator.sv
sss_peak_pick.sv
sss_detector.sv
sss_checker.sv
sss_detector_tb.sv
